//--- common/mem_stage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// data cache geometry
`define MEM_WAYS        8
`define MEM_SETS        64
`define MEM_LINE_BYTES  8

// physical window served through the data cache, bounds inclusive
`define MEM_CACHED_LO   32'h8000_0000
`define MEM_CACHED_HI   32'h8fff_ffff

// cycles allowed for one req/ack exchange on the memory port
`define MEM_ACK_TIMEOUT 64

`endif

//--- common/lsu_pkg.sv
package lsu_pkg;

    // load/store kind as handed over by the execute stage
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LB  = 4'd1,
        OP_LH  = 4'd2,
        OP_LW  = 4'd3,
        OP_LD  = 4'd4,
        OP_LBU = 4'd5,
        OP_LHU = 4'd6,
        OP_LWU = 4'd7,
        OP_SB  = 4'd8,
        OP_SH  = 4'd9,
        OP_SW  = 4'd10,
        OP_SD  = 4'd11
    } mem_op_t;

    typedef logic [2:0] mem_size_t; // log2 of bytes moved

    typedef enum logic [1:0] {
        TRAP_NONE      = 2'd0,
        LOAD_MISALIGN  = 2'd1,
        STORE_MISALIGN = 2'd2
    } trap_t;

endpackage

//--- common/cache_pkg.sv
`include "mem_stage_settings.svh"

package cache_pkg;

    localparam int OFFSET_W = $clog2(`MEM_LINE_BYTES);
    localparam int INDEX_W  = $clog2(`MEM_SETS);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef logic [31:0]           addr_t;
    typedef logic [63:0]           data_t;
    typedef logic [7:0]            strb_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [`MEM_WAYS-1:0]  way_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        DECIDE,
        LOOKUP,
        MEM_REQ,
        MEM_RELEASE,
        FILL,
        MERGE,
        RESPOND
    } ctrl_state_t;

endpackage

//--- logic/access_decode.sv
`include "mem_stage_settings.svh"

module access_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               capture,
    input  lsu_pkg::mem_op_t   in_op,
    input  cache_pkg::addr_t   in_addr,
    input  cache_pkg::data_t   in_wdata,
    output lsu_pkg::mem_op_t   op,
    output logic               is_load,
    output logic               is_store,
    output logic               misalign,
    output logic               cached,
    output cache_pkg::index_t  index,
    output cache_pkg::tag_t    tag,
    output cache_pkg::offset_t offset,
    output cache_pkg::addr_t   mem_addr,
    output lsu_pkg::mem_size_t mem_size,
    output cache_pkg::data_t   st_data,
    output cache_pkg::strb_t   st_strb
);
    import lsu_pkg::*;
    import cache_pkg::*;

    addr_t     addr_q;
    data_t     wdata_q;
    mem_size_t acc_size;
    strb_t     size_mask;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op <= OP_NOP;
        end else if (capture) begin
            op <= in_op;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            addr_q  <= in_addr;
            wdata_q <= in_wdata;
        end
    end

    assign is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
    assign is_store = op inside {OP_SB, OP_SH, OP_SW, OP_SD};

    always_comb begin
        case (op)
            OP_LH, OP_LHU, OP_SH: acc_size = 3'd1;
            OP_LW, OP_LWU, OP_SW: acc_size = 3'd2;
            OP_LD, OP_SD:         acc_size = 3'd3;
            default:              acc_size = 3'd0; // byte kinds and nop
        endcase
    end

    always_comb begin
        case (acc_size)
            3'd1:    size_mask = 8'h03;
            3'd2:    size_mask = 8'h0f;
            3'd3:    size_mask = 8'hff;
            default: size_mask = 8'h01;
        endcase
    end

    assign offset = addr_q[OFFSET_W-1:0];
    assign index  = addr_q[OFFSET_W +: INDEX_W];
    assign tag    = addr_q[31 -: TAG_W];

    // natural alignment: low offset bits below the access size must be zero
    assign misalign = (is_load || is_store) && |(offset & offset_t'((32'd1 << acc_size) - 1));
    assign cached   = (addr_q >= `MEM_CACHED_LO) && (addr_q <= `MEM_CACHED_HI);

    // cached traffic always moves a whole line
    assign mem_addr = cached ? (addr_q & ~addr_t'(`MEM_LINE_BYTES - 1)) : addr_q;
    assign mem_size = cached ? mem_size_t'(OFFSET_W) : acc_size;

    assign st_data = wdata_q << {offset, 3'b000};
    assign st_strb = is_store ? strb_t'(size_mask << offset) : '0;

endmodule

//--- cache/cache_way.sv
`include "mem_stage_settings.svh"

module cache_way (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    input  logic              fill_en,
    input  logic              merge_en,
    input  cache_pkg::data_t  wr_data,
    input  cache_pkg::strb_t  wr_strb,
    output logic              hit,
    output logic              line_valid,
    output cache_pkg::data_t  rd_data
);
    import cache_pkg::*;

    logic [`MEM_SETS-1:0] valid_q;
    tag_t                 tag_mem  [`MEM_SETS];
    data_t                data_mem [`MEM_SETS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= wr_data;   // whole line from memory
        end else if (merge_en) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wr_strb[b]) begin
                    data_mem[index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    assign line_valid = valid_q[index];
    assign hit        = line_valid && (tag_mem[index] == tag);
    assign rd_data    = data_mem[index];

    // controller and way picker never ask one way for both writes
    fill_merge_excl: assert property (@(posedge clk) disable iff (rst)
        !(fill_en && merge_en));

endmodule

//--- cache/way_select.sv
`include "mem_stage_settings.svh"

module way_select (
    input  cache_pkg::way_vec_t                 way_hit,
    input  cache_pkg::way_vec_t                 way_valid,
    input  cache_pkg::data_t [`MEM_WAYS-1:0]    way_data,
    input  logic                                fill,
    input  logic                                merge,
    output logic                                hit_any,
    output cache_pkg::data_t                    hit_data,
    output cache_pkg::way_vec_t                 way_fill,
    output cache_pkg::way_vec_t                 way_merge
);
    import cache_pkg::*;

    way_vec_t first_free;
    way_vec_t victim;

    assign hit_any = |way_hit;

    // lowest hitting way wins
    always_comb begin
        hit_data = '0;
        for (int w = `MEM_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_data = way_data[w];
            end
        end
    end

    assign first_free = ~way_valid & (way_valid + 1'b1);   // lowest clear bit
    assign victim     = (first_free == '0) ? way_vec_t'(1) : first_free;

    assign way_fill  = fill  ? victim  : '0;
    assign way_merge = merge ? way_hit : '0;

    // a refill only happens on a miss, so a tag lives in one way at most
    always_comb begin
        hit_onehot: assert final ($onehot0(way_hit));
    end

endmodule

//--- logic/mem_access_fsm.sv
module mem_access_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic             out_ready,
    input  lsu_pkg::mem_op_t op,
    input  logic             is_load,
    input  logic             is_store,
    input  logic             misalign,
    input  logic             cached,
    input  logic             hit_any,
    input  cache_pkg::data_t hit_data,
    input  logic             mem_ack,
    input  cache_pkg::data_t mem_rdata,
    output logic             in_ready,
    output logic             capture,
    output logic             out_valid,
    output lsu_pkg::trap_t   out_trap,
    output cache_pkg::data_t raw_data,
    output logic             fill,
    output logic             merge,
    output logic             mem_req,
    output logic             mem_we
);
    import lsu_pkg::*;
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        skip;

    assign skip = misalign || (op == OP_NOP);   // answered without touching memory

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_nxt = DECIDE;
                end
            end
            DECIDE: begin
                if (skip) begin
                    state_nxt = RESPOND;
                end else if (is_load && cached) begin
                    state_nxt = LOOKUP;
                end else if (is_load || is_store) begin
                    state_nxt = MEM_REQ;
                end else begin
                    state_nxt = RESPOND;
                end
            end
            LOOKUP: begin
                state_nxt = hit_any ? RESPOND : MEM_REQ;
            end
            MEM_REQ: begin
                if (mem_ack) begin
                    state_nxt = MEM_RELEASE;
                end
            end
            MEM_RELEASE: begin
                // wait for ack to drop before the next phase
                if (!mem_ack) begin
                    if (is_store) begin
                        state_nxt = (cached && hit_any) ? MERGE : RESPOND;
                    end else begin
                        state_nxt = cached ? FILL : RESPOND;
                    end
                end
            end
            FILL:    state_nxt = LOOKUP;    // replay the lookup, now a hit
            MERGE:   state_nxt = RESPOND;
            RESPOND: begin
                if (out_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == DECIDE && skip) begin
            raw_data <= '0;
        end else if (state == LOOKUP && hit_any) begin
            raw_data <= hit_data;
        end else if (state == MEM_REQ && mem_ack) begin
            raw_data <= mem_rdata;  // also the line for a later fill
        end
    end

    assign in_ready  = (state == IDLE);
    assign capture   = in_ready && in_valid;
    assign out_valid = (state == RESPOND);
    assign fill      = (state == FILL);
    assign merge     = (state == MERGE);
    assign mem_req   = (state == MEM_REQ);
    assign mem_we    = mem_req && is_store;

    assign out_trap = !misalign ? TRAP_NONE : (is_store ? STORE_MISALIGN : LOAD_MISALIGN);

    // four-phase rule, request stays up until memory answers
    req_until_ack: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req);

    // response held while downstream stalls
    resp_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(raw_data) && $stable(out_trap));

endmodule

//--- logic/load_align.sv
module load_align (
    input  lsu_pkg::mem_op_t   op,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::data_t   raw_data,
    output cache_pkg::data_t   out_data
);
    import lsu_pkg::*;
    import cache_pkg::*;

    data_t shifted;

    assign shifted = raw_data >> {offset, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (op)
            OP_LB:   out_data = {{56{shifted[7]}}, shifted[7:0]};
            OP_LBU:  out_data = {56'b0, shifted[7:0]};
            OP_LH:   out_data = {{48{shifted[15]}}, shifted[15:0]};
            OP_LHU:  out_data = {48'b0, shifted[15:0]};
            OP_LW:   out_data = {{32{shifted[31]}}, shifted[31:0]};
            OP_LWU:  out_data = {32'b0, shifted[31:0]};
            OP_LD:   out_data = shifted;
            default: out_data = '0;   // stores and nop carry no data
        endcase
    end

endmodule

//--- logic/mem_stage_top.sv
`include "mem_stage_settings.svh"

module mem_stage_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  lsu_pkg::mem_op_t    in_op,
    input  cache_pkg::addr_t    in_addr,
    input  cache_pkg::data_t    in_wdata,
    output logic                in_ready,
    output logic                out_valid,
    output cache_pkg::data_t    out_data,
    output lsu_pkg::trap_t      out_trap,
    input  logic                out_ready,
    output logic                mem_req,
    output logic                mem_we,
    output cache_pkg::addr_t    mem_addr,
    output lsu_pkg::mem_size_t  mem_size,
    output cache_pkg::data_t    mem_wdata,
    output cache_pkg::strb_t    mem_wstrb,
    input  logic                mem_ack,
    input  cache_pkg::data_t    mem_rdata
);
    import lsu_pkg::*;
    import cache_pkg::*;

    mem_op_t                    op;
    logic                       is_load;
    logic                       is_store;
    logic                       misalign;
    logic                       cached;
    logic                       capture;
    index_t                     index;
    tag_t                       tag;
    offset_t                    offset;
    way_vec_t                   way_hit;
    way_vec_t                   way_valid;
    way_vec_t                   way_fill;
    way_vec_t                   way_merge;
    data_t [`MEM_WAYS-1:0]      way_data;
    data_t                      way_wdata;
    data_t                      hit_data;
    data_t                      raw_data;
    logic                       hit_any;
    logic                       fill;
    logic                       merge;

    access_decode i_access_decode (
        .clk(clk), .rst(rst), .capture(capture),
        .in_op(in_op), .in_addr(in_addr), .in_wdata(in_wdata),
        .op(op), .is_load(is_load), .is_store(is_store),
        .misalign(misalign), .cached(cached),
        .index(index), .tag(tag), .offset(offset),
        .mem_addr(mem_addr), .mem_size(mem_size),
        .st_data(mem_wdata), .st_strb(mem_wstrb)
    );

    // refill takes the fetched line, a merge takes the store lanes
    assign way_wdata = merge ? mem_wdata : raw_data;

    for (genvar w = 0; w < `MEM_WAYS; w++) begin : g_way
        cache_way i_cache_way (
            .clk(clk), .rst(rst), .index(index), .tag(tag),
            .fill_en(way_fill[w]), .merge_en(way_merge[w]),
            .wr_data(way_wdata), .wr_strb(mem_wstrb),
            .hit(way_hit[w]), .line_valid(way_valid[w]), .rd_data(way_data[w])
        );
    end

    way_select i_way_select (
        .way_hit(way_hit), .way_valid(way_valid), .way_data(way_data),
        .fill(fill), .merge(merge),
        .hit_any(hit_any), .hit_data(hit_data),
        .way_fill(way_fill), .way_merge(way_merge)
    );

    mem_access_fsm i_mem_access_fsm (
        .clk(clk), .rst(rst), .in_valid(in_valid), .out_ready(out_ready),
        .op(op), .is_load(is_load), .is_store(is_store),
        .misalign(misalign), .cached(cached),
        .hit_any(hit_any), .hit_data(hit_data),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .in_ready(in_ready), .capture(capture),
        .out_valid(out_valid), .out_trap(out_trap), .raw_data(raw_data),
        .fill(fill), .merge(merge), .mem_req(mem_req), .mem_we(mem_we)
    );

    load_align i_load_align (
        .op(op), .offset(offset), .raw_data(raw_data), .out_data(out_data)
    );

endmodule

//--- verification/backing_memory.sv
module backing_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req,
    input  logic               mem_we,
    input  cache_pkg::addr_t   mem_addr,
    input  lsu_pkg::mem_size_t mem_size,
    input  cache_pkg::data_t   mem_wdata,
    input  cache_pkg::strb_t   mem_wstrb,
    output logic               mem_ack,
    output cache_pkg::data_t   mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;
    import cache_pkg::*;

    data_t       words [logic [28:0]];  // keyed by doubleword address
    logic [31:0] lcg_state;
    int          req_count;
    addr_t       last_addr;
    mem_size_t   last_size;
    logic        last_we;

    function automatic logic [31:0] step_lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched doublewords read as their own address and its inverse
    function automatic data_t fill_word(input addr_t a);
        return {a[31:3], 3'b000, ~{a[31:3], 3'b000}};
    endfunction

    function automatic data_t read_word(input addr_t a);
        if (words.exists(a[31:3])) begin
            return words[a[31:3]];
        end
        return fill_word(a);
    endfunction

    task automatic write_word(input addr_t a, input data_t d, input strb_t strb);
        data_t cur;
        cur = read_word(a);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                cur[8*b +: 8] = d[8*b +: 8];
            end
        end
        words[a[31:3]] = cur;
    endtask

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        req_count = 0;
        last_addr = '0;
        last_size = '0;
        last_we   = 1'b0;
        lcg_state = 32'h7bb61dc7;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req && !rst) begin
                lcg_state = step_lcg(lcg_state);
                repeat (lcg_state[17:16]) begin  // answer latency of 0 to 3 cycles
                    @(posedge clk);
                    #1;
                end
                req_count++;
                last_addr = mem_addr;
                last_size = mem_size;
                last_we   = mem_we;
                if (mem_we) begin
                    write_word(mem_addr, mem_wdata, mem_wstrb);
                end
                mem_rdata = read_word(mem_addr);
                mem_ack   = 1'b1;
                while (mem_req) begin
                    @(posedge clk);
                    #1;
                end
                mem_ack = 1'b0;
            end
        end
    end

endmodule

//--- verification/tb_mem_stage.sv
`include "mem_stage_settings.svh"

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;
    import cache_pkg::*;

    localparam int RESP_LIMIT      = `MEM_ACK_TIMEOUT * 4;
    localparam int CYCLES_PER_TEST = `MEM_ACK_TIMEOUT * 4 + 20;

    typedef struct packed {
        mem_op_t op;
        addr_t   addr;
        data_t   wdata;
        data_t   exp_data;
        trap_t   exp_trap;
        int      exp_delta;  // memory requests the operation adds
        logic    bdoor;      // wdata goes into memory by backdoor before the access
    } test_t;

    logic      clk;
    logic      rst;
    logic      in_valid;
    mem_op_t   in_op;
    addr_t     in_addr;
    data_t     in_wdata;
    logic      in_ready;
    logic      out_valid;
    data_t     out_data;
    trap_t     out_trap;
    logic      out_ready;
    logic      mem_req;
    logic      mem_we;
    addr_t     mem_addr;
    mem_size_t mem_size;
    data_t     mem_wdata;
    strb_t     mem_wstrb;
    logic      mem_ack;
    data_t     mem_rdata;

    test_t       tests [$];
    string       names [$];
    logic [31:0] lcg_state;
    int          pass_count;
    int          fail_count;

    mem_stage_top i_mem_stage_top (.*);

    backing_memory i_backing_memory (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] step_lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // log2 of the bytes a RISC-V load or store moves
    function automatic mem_size_t size_of(input mem_op_t op);
        case (op)
            OP_LH, OP_LHU, OP_SH: return 3'd1;
            OP_LW, OP_LWU, OP_SW: return 3'd2;
            OP_LD, OP_SD:         return 3'd3;
            default:              return 3'd0;
        endcase
    endfunction

    // addressed bytes, then sign or zero extension per load kind
    function automatic data_t expect_load(input mem_op_t op, input data_t dword,
                                          input int off);
        data_t res;
        int    nbytes;
        logic  msb;
        res    = '0;
        nbytes = 1 << size_of(op);
        for (int b = 0; b < nbytes; b++) begin
            res[8*b +: 8] = dword[8*(off + b) +: 8];
        end
        msb = res[8*nbytes - 1];
        if (msb && (op inside {OP_LB, OP_LH, OP_LW})) begin
            for (int b = nbytes; b < 8; b++) begin
                res[8*b +: 8] = 8'hff;
            end
        end
        return res;
    endfunction

    task automatic add_test(input string name, input mem_op_t op, input addr_t addr,
                            input data_t wdata, input data_t exp_data, input trap_t exp_trap,
                            input int exp_delta, input logic bdoor);
        test_t t;
        t = '{op, addr, wdata, exp_data, exp_trap, exp_delta, bdoor};
        names.push_back(name);
        tests.push_back(t);
    endtask

    task automatic build_table();
        mem_op_t load_ops [7];
        string   kinds [7];
        data_t   line_data;
        load_ops  = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU};
        kinds     = '{"lb", "lh", "lw", "ld", "lbu", "lhu", "lwu"};
        line_data = 64'h800001007ffffeff;
        // line 0x80000100 reads 8000_0100_7fff_feff until written
        add_test("ld_miss", OP_LD, 32'h80000100, 64'h0, 64'h800001007ffffeff, TRAP_NONE, 1, 1'b0);
        add_test("lb_off0", OP_LB, 32'h80000100, 64'h0, 64'hffffffffffffffff, TRAP_NONE, 0, 1'b0);
        add_test("lb_off5", OP_LB, 32'h80000105, 64'h0, 64'h1, TRAP_NONE, 0, 1'b0);
        add_test("lbu_off1", OP_LBU, 32'h80000101, 64'h0, 64'hfe, TRAP_NONE, 0, 1'b0);
        add_test("lbu_off7", OP_LBU, 32'h80000107, 64'h0, 64'h80, TRAP_NONE, 0, 1'b0);
        add_test("lh_off2", OP_LH, 32'h80000102, 64'h0, 64'h7fff, TRAP_NONE, 0, 1'b0);
        add_test("lh_off6", OP_LH, 32'h80000106, 64'h0, 64'hffffffffffff8000, TRAP_NONE, 0, 1'b0);
        add_test("lhu_off0", OP_LHU, 32'h80000100, 64'h0, 64'hfeff, TRAP_NONE, 0, 1'b0);
        add_test("lw_off0", OP_LW, 32'h80000100, 64'h0, 64'h7ffffeff, TRAP_NONE, 0, 1'b0);
        add_test("lw_off4", OP_LW, 32'h80000104, 64'h0, 64'hffffffff80000100, TRAP_NONE, 0, 1'b0);
        add_test("lwu_off4", OP_LWU, 32'h80000104, 64'h0, 64'h80000100, TRAP_NONE, 0, 1'b0);
        // every load kind at every legal offset of the same line
        for (int k = 0; k < 7; k++) begin
            for (int off = 0; off < 8; off += 1 << size_of(load_ops[k])) begin
                add_test($sformatf("%s_sweep%0d", kinds[k], off), load_ops[k],
                         32'h80000100 + off, 64'h0, expect_load(load_ops[k], line_data, off),
                         TRAP_NONE, 0, 1'b0);
            end
        end
        add_test("nop", OP_NOP, 32'h0, 64'h0, 64'h0, TRAP_NONE, 0, 1'b0);
        add_test("lh_mis", OP_LH, 32'h80000101, 64'h0, 64'h0, LOAD_MISALIGN, 0, 1'b0);
        add_test("lw_mis", OP_LW, 32'h80000102, 64'h0, 64'h0, LOAD_MISALIGN, 0, 1'b0);
        add_test("sd_mis", OP_SD, 32'h80000104, 64'h1, 64'h0, STORE_MISALIGN, 0, 1'b0);
        add_test("sh_mis", OP_SH, 32'h80000103, 64'h1, 64'h0, STORE_MISALIGN, 0, 1'b0);
        add_test("sb_hit", OP_SB, 32'h80000101, 64'haa, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("ld_sb", OP_LD, 32'h80000100, 64'h0, 64'h800001007fffaaff, TRAP_NONE, 0, 1'b0);
        add_test("sh_hit", OP_SH, 32'h80000106, 64'h1234, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("ld_sh", OP_LD, 32'h80000100, 64'h0, 64'h123401007fffaaff, TRAP_NONE, 0, 1'b0);
        add_test("sw_hit", OP_SW, 32'h80000100, 64'hdeadbeef, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("ld_sw", OP_LD, 32'h80000100, 64'h0, 64'h12340100deadbeef, TRAP_NONE, 0, 1'b0);
        add_test("sd_hit", OP_SD, 32'h80000100, 64'h0123456789abcdef, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("ld_sd", OP_LD, 32'h80000100, 64'h0, 64'h0123456789abcdef, TRAP_NONE, 0, 1'b0);
        add_test("sw_miss", OP_SW, 32'h8000020c, 64'h55556666, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("ld_swm", OP_LD, 32'h80000208, 64'h0, 64'h555566667ffffdf7, TRAP_NONE, 1, 1'b0);
        add_test("sb_unc", OP_SB, 32'h20000013, 64'h5a, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("ld_unc", OP_LD, 32'h20000010, 64'h0, 64'h200000105affffef, TRAP_NONE, 1, 1'b0);
        add_test("sh_unc", OP_SH, 32'h20000014, 64'hbeef, 64'h0, TRAP_NONE, 1, 1'b0);
        add_test("lhu_unc", OP_LHU, 32'h20000014, 64'h0, 64'hbeef, TRAP_NONE, 1, 1'b0);
        add_test("bdoor_unc", OP_LW, 32'h20000014, 64'h0f0f0f0ff0f0f0f0, 64'h0f0f0f0f,
                 TRAP_NONE, 1, 1'b1);
        add_test("bdoor_hit", OP_LD, 32'h80000100, 64'hffff0000ffff0000, 64'h0123456789abcdef,
                 TRAP_NONE, 0, 1'b1);
        // eight more tags at set 32, the last one evicts way 0
        add_test("ld_t1", OP_LD, 32'h80000300, 64'h0, 64'h800003007ffffcff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t2", OP_LD, 32'h80000500, 64'h0, 64'h800005007ffffaff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t3", OP_LD, 32'h80000700, 64'h0, 64'h800007007ffff8ff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t4", OP_LD, 32'h80000900, 64'h0, 64'h800009007ffff6ff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t5", OP_LD, 32'h80000b00, 64'h0, 64'h80000b007ffff4ff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t6", OP_LD, 32'h80000d00, 64'h0, 64'h80000d007ffff2ff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t7", OP_LD, 32'h80000f00, 64'h0, 64'h80000f007ffff0ff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t8", OP_LD, 32'h80001100, 64'h0, 64'h800011007fffeeff, TRAP_NONE, 1, 1'b0);
        add_test("ld_t1_hit", OP_LD, 32'h80000300, 64'h0, 64'h800003007ffffcff, TRAP_NONE, 0, 1'b0);
        add_test("ld_evicted", OP_LD, 32'h80000100, 64'h0, 64'hffff0000ffff0000,
                 TRAP_NONE, 1, 1'b0);
    endtask

    task automatic run_test(input int i);
        test_t t;
        string nm;
        int    req_before;
        int    cycles;
        logic  ok;
        logic  is_cached;
        logic  exp_we;
        addr_t exp_addr;
        data_t got_data;
        trap_t got_trap;
        t         = tests[i];
        nm        = names[i];
        ok        = 1'b1;
        is_cached = (t.addr >= `MEM_CACHED_LO) && (t.addr <= `MEM_CACHED_HI);
        exp_we    = t.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
        if (t.bdoor) begin
            i_backing_memory.write_word(t.addr, t.wdata, 8'hff);
        end
        req_before = i_backing_memory.req_count;
        in_valid   = 1'b1;
        in_op      = t.op;
        in_addr    = t.addr;
        in_wdata   = t.wdata;
        cycles     = 0;
        while (!in_ready && cycles < RESP_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        @(posedge clk);  // transfer edge
        #1;
        in_valid = 1'b0;
        cycles   = 0;
        while (!out_valid && cycles < RESP_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (out_valid) else begin
            $display("%s: no response within %0d cycles", nm, RESP_LIMIT);
            ok = 1'b0;
        end
        got_data  = out_data;
        got_trap  = out_trap;
        lcg_state = step_lcg(lcg_state);
        repeat (lcg_state[27:26]) begin  // downstream stall
            @(posedge clk);
            #1;
            assert (out_valid && out_data == got_data && out_trap == got_trap && !in_ready)
            else begin
                $display("%s: response did not hold while out_ready was low", nm);
                ok = 1'b0;
            end
        end
        out_ready = 1'b1;
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        assert (!out_valid && in_ready) else begin
            $display("%s: response still pending after it was taken", nm);
            ok = 1'b0;
        end
        assert (got_data == t.exp_data) else begin
            $display("FAIL %s data: expected %h, actual %h", nm, t.exp_data, got_data);
            ok = 1'b0;
        end
        assert (got_trap == t.exp_trap) else begin
            $display("FAIL %s trap: expected %0d, actual %0d", nm, t.exp_trap, got_trap);
            ok = 1'b0;
        end
        assert (i_backing_memory.req_count - req_before == t.exp_delta) else begin
            $display("FAIL %s requests: expected %0d, actual %0d", nm, t.exp_delta,
                     i_backing_memory.req_count - req_before);
            ok = 1'b0;
        end
        if (t.exp_delta != 0) begin
            exp_addr = is_cached ? {t.addr[31:3], 3'b000} : t.addr;
            assert (i_backing_memory.last_addr == exp_addr) else begin
                $display("FAIL %s mem_addr: expected %h, actual %h", nm, exp_addr,
                         i_backing_memory.last_addr);
                ok = 1'b0;
            end
            assert (i_backing_memory.last_size == (is_cached ? 3'd3 : size_of(t.op))) else begin
                $display("FAIL %s mem_size: expected %0d, actual %0d", nm,
                         is_cached ? 3'd3 : size_of(t.op), i_backing_memory.last_size);
                ok = 1'b0;
            end
            assert (i_backing_memory.last_we == exp_we) else begin
                $display("FAIL %s mem_we: expected %0d, actual %0d", nm, exp_we,
                         i_backing_memory.last_we);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s %s", i, nm, ok ? "ok" : "failed");
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = OP_NOP;
        in_addr    = '0;
        in_wdata   = '0;
        out_ready  = 1'b0;
        lcg_state  = 32'h7bb61dc7;
        pass_count = 0;
        fail_count = 0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (in_ready && !out_valid && !mem_req) else begin
            $display("in_ready, out_valid or mem_req wrong after reset");
            fail_count++;
        end
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        $display("%0d tests: %0d passed, %0d failed", tests.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #1;  // table is built at time zero
        repeat (tests.size() * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired after %0d cycles", tests.size() * CYCLES_PER_TEST);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- mem_stage_top.f
+incdir+common
common/lsu_pkg.sv
common/cache_pkg.sv
logic/access_decode.sv
cache/cache_way.sv
cache/way_select.sv
logic/mem_access_fsm.sv
logic/load_align.sv
logic/mem_stage_top.sv
verification/backing_memory.sv
verification/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
    echo "cannot create build directory"
    exit 1
fi

verilator --binary --timing --assert --top-module tb_mem_stage \
    -f mem_stage_top.f -Mdir build/obj_dir -o tb_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/obj_dir/tb_mem_stage > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" build/sim.log; then
    exit 1
fi
exit 0
